/* tb.f */
+incdir+design
design/thor_pkg.sv
design/ins_length.sv
design/ins_mem.sv
design/ins_fetch.sv
design/ins_fetch_top.sv
dv/tb_top.sv

/* Makefile */
# Verilator build and run for the fetch front end testbench

TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_top
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The run passes only if the log holds the pass line
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/tb_top.sv */
// Testbench for the fetch front end with random programs, a reference model and a checker
`include "thor_defines.svh"

module tb_top
  import thor_pkg::*;
;

  // ====================
  // Run limits
  // ====================

  // Five runs of at most 200 instructions, up to 10 cycles each under hold, plus margin
  localparam int MAX_CYCLES = 20000;
  localparam int MAX_WALK   = 200;
  localparam logic [31:0] SEED = 32'h3532;

  logic                clk;
  logic                reset;
  logic                prog_we;
  logic [`ADDR_W-2:0]  prog_addr;
  parcel_t             prog_data;
  logic                start;
  byte_addr_t          start_pc;
  logic                hold;
  logic                ins_valid;
  instruction_t        ins;
  byte_addr_t          ins_pc;
  ins_len_t            ins_len;
  logic                halted;

  // Shadow of every program write that the model reads instructions from
  parcel_t model_mem [`MEM_PARCELS];

  // Expected issue sequence from the model walk
  byte_addr_t exp_pc [$];
  ins_len_t   exp_len [$];

  // Named opcodes first, then one entry per wildcard row
  opcode_t cover_ops [20];

  int errors;
  int tests_passed;
  int tests_failed;
  int cycle_count;

  ins_fetch_top DUT (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .start     (start),
    .start_pc  (start_pc),
    .hold      (hold),
    .ins_valid (ins_valid),
    .ins       (ins),
    .ins_pc    (ins_pc),
    .ins_len   (ins_len),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Hard stop in case the DUT never halts
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ====================
  // Reference model
  // ====================

  // Length in bytes straight from the opcode table
  function automatic ins_len_t model_len(input opcode_t op);
    logic [3:0] row;
    row = op[7:4];
    if (op == EXI55) return 4'd8;
    if (row == 4'h2 || row == 4'h3 || row == 4'hD || row == 4'hE) return 4'd6;
    if (op == R2 || op == ADDIL || op == ANDIL || op == LDO || op == STO || op == EXI41) begin
      return 4'd6;
    end
    if (op == R1 || op == ADDI || op == ANDI || op == EXI23) return 4'd4;
    return 4'd2;
  endfunction

  // Little-endian byte fetch from the shadow memory
  function automatic logic [7:0] model_byte(input byte_addr_t addr);
    parcel_t p;
    p = model_mem[addr[`ADDR_W-1:1]];
    return addr[0] ? p[15:8] : p[7:0];
  endfunction

  // Expected window with the bytes past len cleared
  function automatic instruction_t model_window(input byte_addr_t pc, input ins_len_t len);
    instruction_t w;
    w = '0;
    for (int b = 0; b < int'(len); b++) begin
      w[b*8 +: 8] = model_byte(pc + byte_addr_t'(b));
    end
    return w;
  endfunction

  function automatic instruction_t len_mask(input ins_len_t len);
    instruction_t m;
    m = '0;
    for (int b = 0; b < int'(len); b++) begin
      m[b*8 +: 8] = 8'hFF;
    end
    return m;
  endfunction

  // Walk the shadow program until BRK and queue what the DUT should issue
  task automatic model_walk(input byte_addr_t pc0);
    byte_addr_t pc;
    ins_len_t   len;
    exp_pc.delete();
    exp_len.delete();
    pc = pc0;
    for (int i = 0; i < MAX_WALK; i++) begin
      len = model_len(model_byte(pc));
      exp_pc.push_back(pc);
      exp_len.push_back(len);
      if (model_byte(pc) == BRK) break;
      pc = pc + byte_addr_t'(len);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("ERR %s: expected 0x%0h, got 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  // ====================
  // Program generation
  // ====================

  task automatic write_parcel(input logic [`ADDR_W-2:0] idx, input parcel_t data);
    @(posedge clk);
    prog_we   <= 1'b1;
    prog_addr <= idx;
    prog_data <= data;
    model_mem[idx] = data;
  endtask

  // Kind 0 covers the opcode table, kind 1 mixes all four lengths, others are random
  function automatic opcode_t pick_opcode(input int kind, input int i);
    opcode_t op;
    if (kind == 0) begin
      if (i < 16) op = cover_ops[i];
      else if (i < 20) op = cover_ops[i] | opcode_t'($urandom % 16);
      else op = opcode_t'($urandom);
    end else if (kind == 1) begin
      case ($urandom % 4)
        0: op = (i % 2 == 0) ? NOP : PUSH;
        1: op = (i % 2 == 0) ? ADDI : EXI23;
        2: op = (i % 2 == 0) ? LDO : opcode_t'(8'hE0 | ($urandom % 16));
        default: op = EXI55;
      endcase
    end else begin
      op = opcode_t'($urandom);
    end
    // A BRK only ever ends a program
    if (op == BRK) op = NOP;
    return op;
  endfunction

  task automatic gen_program(input byte_addr_t pc0, input int count, input int kind);
    byte_addr_t pc;
    byte_addr_t pc_k;
    opcode_t    op;
    ins_len_t   len;
    pc = pc0;
    for (int i = 0; i < count; i++) begin
      op  = (i == count - 1) ? BRK : pick_opcode(kind, i);
      len = model_len(op);
      write_parcel(pc[`ADDR_W-1:1], {8'($urandom), op});
      for (int k = 1; k < int'(len) / 2; k++) begin
        pc_k = pc + byte_addr_t'(2 * k);
        write_parcel(pc_k[`ADDR_W-1:1], parcel_t'($urandom));
      end
      pc = pc + byte_addr_t'(len);
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  // ====================
  // Fetch run and checks
  // ====================

  // Starts a fetch, checks every issue against the model, then watches the halt
  // A spurious start is pulsed at cycle spurious_at when that is not negative
  task automatic run_fetch(input byte_addr_t pc0, input bit use_hold, input int spurious_at,
                           input int quiet_cycles, output int issued);
    int cyc;
    bit done;
    model_walk(pc0);
    issued = 0;
    cyc    = 0;
    done   = 1'b0;
    @(posedge clk);
    start    <= 1'b1;
    start_pc <= pc0;
    @(posedge clk);
    start <= 1'b0;
    while (!done) begin
      // Look at the outputs half a cycle after the driving edge
      @(negedge clk);
      check_value("ins_valid under hold", 64'(0), 64'(ins_valid & hold));
      if (ins_valid) begin
        if (issued >= exp_pc.size()) begin
          $display("Instruction issued at pc 0x%0h after the model's BRK", ins_pc);
          errors++;
        end else begin
          check_value("ins_pc", 64'(exp_pc[issued]), 64'(ins_pc));
          check_value("ins_len", 64'(exp_len[issued]), 64'(ins_len));
          check_value("ins", model_window(exp_pc[issued], exp_len[issued]),
                      ins & len_mask(exp_len[issued]));
        end
        issued++;
      end
      if (halted) done = 1'b1;
      @(posedge clk);
      cyc++;
      if (use_hold) hold <= 1'($urandom % 2);
      if (cyc == spurious_at) begin
        start    <= 1'b1;
        start_pc <= pc0 + 9'h040;
      end else begin
        start <= 1'b0;
      end
    end
    hold <= 1'b0;
    check_value("issued count", 64'(exp_pc.size()), 64'(issued));
    // Nothing more may come out until the next start
    repeat (quiet_cycles) begin
      @(negedge clk);
      check_value("ins_valid after halt", 64'(0), 64'(ins_valid));
      check_value("halted", 64'(1), 64'(halted));
    end
  endtask

  task automatic report_test(input string name, input int err_before, input int issued);
    if (errors == err_before) begin
      tests_passed++;
      $display("%s: passed, %0d instructions", name, issued);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    int err_before;
    int n_first;
    int n;
    void'($urandom(SEED));
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cover_ops = '{R1, R2, ADDI, ADDIL, ANDI, ANDIL, LDO, STO, NOP, RTS, PUSH, POP,
                  EXI7, EXI23, EXI41, EXI55, 8'h20, 8'h30, 8'hD0, 8'hE0};
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    start     = 1'b0;
    start_pc  = '0;
    hold      = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // Test 1 covers every named opcode and row with the first start from IDLE
    err_before = errors;
    gen_program(9'h040, 24, 0);
    run_fetch(9'h040, 1'b0, -1, 4, n_first);
    report_test("test 1 length decode", err_before, n_first);

    // Test 4 reruns the same program, so it goes before memory is rewritten
    err_before = errors;
    run_fetch(9'h040, 1'b1, -1, 4, n);
    check_value("issued count vs test 1", 64'(n_first), 64'(n));
    report_test("test 4 back-pressure", err_before, n);

    // Test 2 starts near the top so both windows and the pc wrap
    err_before = errors;
    gen_program(9'h1F0, 14, 1);
    run_fetch(9'h1F0, 1'b0, -1, 4, n);
    report_test("test 2 alignment", err_before, n);

    // Test 3 holds the halted state for a longer watch
    err_before = errors;
    gen_program(9'h100, 6, 2);
    run_fetch(9'h100, 1'b0, -1, 24, n);
    report_test("test 3 halt", err_before, n);

    // Test 5 reprograms from HALT and pulses start mid-run
    err_before = errors;
    gen_program(9'h0A0, 30, 2);
    run_fetch(9'h0A0, 1'b0, 4, 4, n);
    report_test("test 5 restart and reprogram", err_before, n);

    $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* design/ins_fetch_top.sv */
// Fetch front end top, ties program memory, fetch FSM and length decoder together
`include "thor_defines.svh"

module ins_fetch_top
  import thor_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               prog_we,
  input  logic [`ADDR_W-2:0] prog_addr,
  input  parcel_t            prog_data,
  input  logic               start,
  input  byte_addr_t         start_pc,
  input  logic               hold,
  output logic               ins_valid,
  output instruction_t       ins,
  output byte_addr_t         ins_pc,
  output ins_len_t           ins_len,
  output logic               halted
);

  // Read request from fetch to memory
  logic       rd_en;
  byte_addr_t rd_pc;

  // Registered memory window, also fed to the decoder
  instruction_t window;

  // Decoded length of the window's instruction
  ins_len_t len;

  ins_mem u_ins_mem (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .rd_en     (rd_en),
    .rd_pc     (rd_pc),
    .window    (window)
  );

  // Combinational, so the length is ready in the same cycle as the window
  ins_length u_ins_length (
    .ir  (window),
    .len (len)
  );

  ins_fetch u_ins_fetch (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .start_pc  (start_pc),
    .hold      (hold),
    .rd_en     (rd_en),
    .rd_pc     (rd_pc),
    .window    (window),
    .len       (len),
    .ins_valid (ins_valid),
    .ins       (ins),
    .ins_pc    (ins_pc),
    .ins_len   (ins_len),
    .halted    (halted)
  );

endmodule

/* design/ins_fetch.sv */
// Fetch FSM that walks the program, issues aligned instructions and halts after BRK
`include "thor_defines.svh"

module ins_fetch
  import thor_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         start,
  input  byte_addr_t   start_pc,
  input  logic         hold,
  output logic         rd_en,
  output byte_addr_t   rd_pc,
  input  instruction_t window,
  input  ins_len_t     len,
  output logic         ins_valid,
  output instruction_t ins,
  output byte_addr_t   ins_pc,
  output ins_len_t     ins_len,
  output logic         halted
);

  fetch_state_t state;
  fetch_state_t state_next;

  // Byte address of the instruction being fetched or issued
  byte_addr_t pc;
  byte_addr_t pc_next;

  // Decoded length widened to address width for the pc add
  byte_addr_t len_ext;

  // High while the window holds a BRK
  logic is_brk;

  // Issue handshake of the current cycle
  logic issue;

  assign len_ext = {{(`ADDR_W - 4){1'b0}}, len};
  assign is_brk  = (window[7:0] == BRK);
  assign issue   = (state == ISSUE) && !hold;

  // ====================
  // Next state
  // ====================

  always_comb begin
    state_next = state;
    pc_next    = pc;
    case (state)
      // Idle and halted both wait for a start pulse
      IDLE, HALT: begin
        if (start) begin
          state_next = READ;
          pc_next    = start_pc;
        end
      end

      // Single read cycle, the window lands at the next edge
      READ: begin
        state_next = ISSUE;
      end

      // Stay here while held, the window register keeps its value
      ISSUE: begin
        if (issue) begin
          // Address space wraps, same as the memory
          pc_next = pc + len_ext;
          if (is_brk) begin
            state_next = HALT;
          end else begin
            state_next = READ;
          end
        end
      end

      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // ====================
  // Registers
  // ====================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      pc    <= '0;
    end else begin
      state <= state_next;
      pc    <= pc_next;
    end
  end

  // ====================
  // Outputs
  // ====================

  // Memory request for the current pc
  assign rd_en = (state == READ);
  assign rd_pc = pc;

  // Issue strobe drops while hold is high, so back-pressure costs no data
  assign ins_valid = issue;

  // Whole window goes out, bytes past ins_len are don't-care for the consumer
  assign ins     = window;
  assign ins_pc  = pc;
  assign ins_len = len;

  // Level until the next start pulse
  assign halted = (state == HALT);

endmodule

/* design/ins_mem.sv */
// Program memory of 16-bit parcels with a write port and a registered 64-bit read window
`include "thor_defines.svh"

module ins_mem
  import thor_pkg::*;
(
  input  logic                clk,
  input  logic                prog_we,
  input  logic [`ADDR_W-2:0]  prog_addr,
  input  parcel_t             prog_data,
  input  logic                rd_en,
  input  byte_addr_t          rd_pc,
  output instruction_t        window
);

  // Parcel index width, one bit less than a byte address
  localparam int IDX_W = `ADDR_W - 1;

  parcel_t mem [`MEM_PARCELS];

  // Parcel indices of the four words in the read window
  logic [IDX_W-1:0] idx0;
  logic [IDX_W-1:0] idx1;
  logic [IDX_W-1:0] idx2;
  logic [IDX_W-1:0] idx3;

  // Drop the byte bit, then step through parcels
  // The index width matches the memory depth, so the adds wrap at the top
  assign idx0 = rd_pc[`ADDR_W-1:1];
  assign idx1 = idx0 + IDX_W'(1);
  assign idx2 = idx0 + IDX_W'(2);
  assign idx3 = idx0 + IDX_W'(3);

  // Program load port
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // Read window, first parcel in the low bits
  // Holds its value while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      window <= {mem[idx3], mem[idx2], mem[idx1], mem[idx0]};
    end
  end

endmodule

/* design/ins_length.sv */
// Instruction length decoder that maps an instruction's opcode to its size in bytes
module ins_length
  import thor_pkg::*;
(
  input  instruction_t ir,
  output ins_len_t     len
);

  // Opcode lives in the low byte of the first parcel
  opcode_t opcode;

  assign opcode = ir[7:0];

  // ====================
  // Length table
  // ====================

  // Only the opcode matters here
  // Anything not listed is treated as a single parcel
  always_comb begin
    casez (opcode)
      // Longest form with an opcode and a 55-bit immediate extension
      EXI55: begin
        len = 4'd8;
      end

      // Three parcel forms with a long immediate or displacement
      R2, ADDIL, ANDIL, LDO, STO, EXI41: begin
        len = 4'd6;
      end

      // Branch rows
      8'h2?, 8'h3?: begin
        len = 4'd6;
      end

      // Indexed load and store rows
      8'hD?, 8'hE?: begin
        len = 4'd6;
      end

      // Two parcel forms with a short immediate
      R1, ADDI, ANDI, EXI23: begin
        len = 4'd4;
      end

      // Single parcel forms such as BRK, NOP, RTS, PUSH, POP and EXI7
      default: begin
        len = 4'd2;
      end
    endcase
  end

endmodule

/* design/thor_pkg.sv */
// Thor fetch front end types, fetch state encoding and opcode constants
`include "thor_defines.svh"

package thor_pkg;

  // ====================
  // Vector types
  // ====================

  // Primary opcode, always the first byte of an instruction
  typedef logic [7:0] opcode_t;

  // Instruction length in bytes, one of 2, 4, 6 or 8
  typedef logic [3:0] ins_len_t;

  // One 16-bit word of program memory
  typedef logic [15:0] parcel_t;

  // Four parcels, little-endian, opcode in bits 7 to 0
  typedef logic [63:0] instruction_t;

  // Byte address into program memory
  // Instructions are parcel aligned so bit 0 stays clear
  typedef logic [`ADDR_W-1:0] byte_addr_t;

  // ====================
  // Fetch FSM states
  // ====================

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    READ  = 2'd1,
    ISSUE = 2'd2,
    HALT  = 2'd3
  } fetch_state_t;

  // ====================
  // Opcodes
  // ====================

  // Break, also stops the fetch unit
  localparam opcode_t BRK   = 8'h00;

  // Register forms
  localparam opcode_t R1    = 8'h01;
  localparam opcode_t R2    = 8'h02;

  // Immediate arithmetic and logic, short and long immediates
  localparam opcode_t ADDI  = 8'h04;
  localparam opcode_t ADDIL = 8'h44;
  localparam opcode_t ANDI  = 8'h08;
  localparam opcode_t ANDIL = 8'h48;

  // Displacement load and store
  localparam opcode_t LDO   = 8'h86;
  localparam opcode_t STO   = 8'h96;

  // Single parcel housekeeping
  localparam opcode_t NOP   = 8'hF1;
  localparam opcode_t RTS   = 8'hF2;
  localparam opcode_t PUSH  = 8'hF8;
  localparam opcode_t POP   = 8'hF9;

  // Immediate extension prefixes, named after the bits they carry
  localparam opcode_t EXI7  = 8'h50;
  localparam opcode_t EXI23 = 8'h51;
  localparam opcode_t EXI41 = 8'h52;
  localparam opcode_t EXI55 = 8'h53;

  // Rows 2x and 3x hold branches, rows Dx and Ex the indexed loads and stores
  // They are matched as whole rows in the length decoder

endpackage

/* design/thor_defines.svh */
// Thor fetch front end sizing macros for program memory and byte addressing
`ifndef THOR_DEFINES_SVH
`define THOR_DEFINES_SVH

// Number of 16-bit parcels held in the program memory
`define MEM_PARCELS 256

// Width of a byte address into program memory
// Two bytes per parcel, so one bit more than the parcel index
`define ADDR_W 9

`endif
